// File: crc_macros.svh
/*
 * Global constants for the CRC24 burst checker.
 * CRC_W and WORD_W are fixed by the packed types and must not be changed alone.
 * MAX_BURST_WORDS also sizes the burst word counter.
 */
`ifndef CRC_MACROS_SVH
`define CRC_MACROS_SVH

// generator polynomial, MSB first, x^24 term implied
`define CRC_POLY 24'h328B63

// residue width
`define CRC_W 24

// stream word width
`define WORD_W 64

// bursts longer than this are flagged as too long
`define MAX_BURST_WORDS 256

`endif

// File: word_pkg.sv
/*
 * Stream word types for the receive side.
 * A control word carries its CRC field in the low bits.
 * Lane striping and 64b/67b framing are stripped before this point.
 */
`include "crc_macros.svh"

package word_pkg;

	// control view of one stream word
	typedef struct packed {
		logic [7:0] ctrl_type;
		// reserved, still covered by the CRC
		logic [`WORD_W-`CRC_W-9:0] rsvd;
		// received CRC, zero while computing
		logic [`CRC_W-1:0] crc;
	} ctrl_fields_t;

	// one word read either as raw CRC input or as control fields
	typedef union packed {
		logic [`WORD_W-1:0] data;
		ctrl_fields_t ctrl;
	} stream_word_u;

	// word plus its side flags
	typedef struct packed {
		stream_word_u word;
		logic is_ctrl;
		logic valid;
	} stream_in_t;

endpackage

// File: crc_pkg.sv
/*
 * CRC side types shared by the checker blocks.
 * cover_t only takes the values 0, 1 and 2.
 */
`include "crc_macros.svh"

package crc_pkg;

	// residue or per-word contribution
	typedef logic [`CRC_W-1:0] crc24_t;

	// previous words folded into the rolling CRC
	typedef logic [3:0] cover_t;

	// per-burst report
	typedef struct packed {
		// computed over data words and closing control word
		crc24_t crc;
		// field taken from the closing control word
		crc24_t rx_crc;
		logic crc_err;
		logic too_long;
		// one enabled cycle wide
		logic valid;
	} burst_result_t;

endpackage

// File: crc24_word_evo.sv
/*
 * Per-word CRC24 contribution from an all-zero start, MSB first.
 * In control words the CRC field counts as zero.
 * evo is held between valid words, evo_valid follows rx.valid by one enabled cycle.
 */
`timescale 1ns/1ps
`include "crc_macros.svh"

module crc24_word_evo (
	input  logic                clk,
	input  logic                arst,
	input  logic                ena,
	input  word_pkg::stream_in_t rx,
	output crc_pkg::crc24_t     evo,
	output logic                evo_valid
);

	import word_pkg::*;
	import crc_pkg::*;

	stream_word_u masked;

	// bitwise update, unrolls into one XOR tree per residue bit
	function automatic crc24_t word_contrib(input logic [`WORD_W-1:0] data);
		crc24_t c;
		logic fb;
		c = '0;
		for (int i = `WORD_W - 1; i >= 0; i--) begin
			fb = c[`CRC_W-1] ^ data[i];
			c = {c[`CRC_W-2:0], 1'b0} ^ ({`CRC_W{fb}} & `CRC_POLY);
		end
		return c;
	endfunction

	// blank the received CRC before it feeds the tree
	always_comb begin
		masked = rx.word;
		if (rx.is_ctrl) begin
			masked.ctrl.crc = '0;
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			evo_valid <= 1'b0;
		end else if (ena) begin
			evo_valid <= rx.valid;
		end
	end

	// contribution register, loaded on accepted words only
	always_ff @(posedge clk) begin
		if (ena && rx.valid) begin
			evo <= word_contrib(masked.data);
		end
	end

endmodule

// File: crc24_zero_adv.sv
/*
 * Advances a CRC24 residue through N_WORDS all-zero stream words.
 * N_WORDS from 1 to 3. Pure combinational, one XOR matrix.
 */
`timescale 1ns/1ps
`include "crc_macros.svh"

module crc24_zero_adv #(
	parameter int N_WORDS = 1
) (
	input  crc_pkg::crc24_t c,
	output crc_pkg::crc24_t crc_out
);

	import crc_pkg::*;

	localparam int N_BITS = N_WORDS * `WORD_W;

	// row j is the image of residue bit j after N_BITS zero shifts
	function automatic logic [`CRC_W-1:0][`CRC_W-1:0] build_matrix();
		logic [`CRC_W-1:0][`CRC_W-1:0] m;
		crc24_t col;
		for (int j = 0; j < `CRC_W; j++) begin
			col = crc24_t'(1) << j;
			for (int b = 0; b < N_BITS; b++) begin
				col = {col[`CRC_W-2:0], 1'b0} ^ ({`CRC_W{col[`CRC_W-1]}} & `CRC_POLY);
			end
			m[j] = col;
		end
		return m;
	endfunction

	localparam logic [`CRC_W-1:0][`CRC_W-1:0] ADV_M = build_matrix();

	// linear map, so the result is the XOR of the rows picked by c
	always_comb begin
		crc_out = '0;
		for (int j = 0; j < `CRC_W; j++) begin
			crc_out ^= ADV_M[j] & {`CRC_W{c[j]}};
		end
	end

endmodule

// File: crc24_combine.sv
/*
 * Folds the current contribution with up to two earlier ones into the rolling CRC.
 * Latency is 2 enabled cycles from evo_dat_0 to crc_out.
 * evo_dat_n2 must be crc_out itself, evo_dat_n1 the contribution of the previous word.
 * covered of 0 restarts the CRC from the all-ones seed.
 */
`timescale 1ns/1ps

module crc24_combine (
	input  logic            clk,
	input  logic            arst,
	input  logic            ena,
	input  logic            valid,
	input  crc_pkg::cover_t covered,
	input  crc_pkg::crc24_t evo_dat_0,
	input  crc_pkg::crc24_t evo_dat_n1,
	input  crc_pkg::crc24_t evo_dat_n2,
	output crc_pkg::crc24_t crc_out
);

	import crc_pkg::*;

	localparam crc24_t CRC_INIT = '1;

	crc24_t adv1_init;
	crc24_t adv2_init;
	crc24_t adv3_init;
	crc24_t adv_n1;
	crc24_t adv2_n2;
	cover_t last_covered;
	logic last_valid;
	crc24_t evo_dat_0_r;
	crc24_t n1_term;
	crc24_t roll_term;
	crc24_t seed_term;

	//////////////////////////////
	// seed advanced by 1, 2 and 3 words, constant after elaboration
	crc24_zero_adv #(.N_WORDS(1)) u_init_x1 (.c(CRC_INIT), .crc_out(adv1_init));
	crc24_zero_adv #(.N_WORDS(2)) u_init_x2 (.c(CRC_INIT), .crc_out(adv2_init));
	crc24_zero_adv #(.N_WORDS(3)) u_init_x3 (.c(CRC_INIT), .crc_out(adv3_init));

	// previous word moved one word on
	crc24_zero_adv #(.N_WORDS(1)) u_n1_x1 (.c(evo_dat_n1), .crc_out(adv_n1));
	// rolling CRC two words back, moved two words on
	crc24_zero_adv #(.N_WORDS(2)) u_n2_x2 (.c(evo_dat_n2), .crc_out(adv2_n2));

	//////////////////////////////
	// control stage
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			last_covered <= '0;
			last_valid <= 1'b0;
		end else if (ena) begin
			last_covered <= covered;
			last_valid <= valid;
		end
	end

	// first stage of the data paths
	always_ff @(posedge clk) begin
		if (ena) begin
			evo_dat_0_r <= evo_dat_0;
			// n1 only counts once the burst has a previous word
			if (covered == cover_t'(1) || covered == cover_t'(2)) begin
				n1_term <= adv_n1;
			end else begin
				n1_term <= '0;
			end
		end
		// sampled as a word commits, crc_out still holds the one before it
		if (ena && last_valid) begin
			roll_term <= adv2_n2;
		end
	end

	// seed or rolling history by registered covered
	always_comb begin
		case (last_covered)
			cover_t'(0): seed_term = adv1_init;
			cover_t'(1): seed_term = adv2_init;
			cover_t'(2): seed_term = roll_term;
			// out-of-range counts see three words of pure seed
			default: seed_term = adv3_init;
		endcase
	end

	//////////////////////////////
	// commit stage
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			crc_out <= CRC_INIT;
		end else if (ena && last_valid) begin
			crc_out <= evo_dat_0_r ^ seed_term ^ n1_term;
		end
	end

endmodule

// File: burst_counter.sv
/*
 * Word count of the current burst, the closing control word included.
 * The count saturates one past MAX_BURST_WORDS.
 * too_long is registered and covers the whole burst one enabled cycle after its last word.
 */
`timescale 1ns/1ps
`include "crc_macros.svh"

module burst_counter (
	input  logic            clk,
	input  logic            arst,
	input  logic            ena,
	input  logic            burst_start,
	input  logic            word_acc,
	output crc_pkg::cover_t covered,
	output logic            too_long
);

	import crc_pkg::*;

	localparam int CNT_W = $clog2(`MAX_BURST_WORDS + 2);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`MAX_BURST_WORDS);

	// words already taken in this burst
	logic [CNT_W-1:0] count;

	// index of the present word, clamped at 2
	always_comb begin
		if (burst_start) begin
			covered = cover_t'(0);
		end else if (count == CNT_W'(1)) begin
			covered = cover_t'(1);
		end else begin
			covered = cover_t'(2);
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			count <= '0;
			too_long <= 1'b0;
		end else if (ena && word_acc) begin
			if (burst_start) begin
				count <= CNT_W'(1);
				too_long <= 1'b0;
			end else begin
				// stop one past the limit
				if (count <= CNT_MAX) begin
					count <= count + 1'b1;
				end
				too_long <= (count >= CNT_MAX);
			end
		end
	end

endmodule

// File: burst_fsm.sv
/*
 * Burst framing on the control word flag.
 * Data before the first control word is dropped.
 * A control word right after another one is an empty burst and gives no result.
 * result_strobe trails burst_close by 3 enabled cycles.
 */
`timescale 1ns/1ps

module burst_fsm (
	input  logic clk,
	input  logic arst,
	input  logic ena,
	input  logic in_valid,
	input  logic in_ctrl,
	output logic burst_start,
	output logic word_acc,
	output logic burst_close,
	output logic result_strobe
);

	// CLOSE means the last accepted word was a control word
	typedef enum logic [1:0] {
		IDLE,
		BURST,
		CLOSE
	} state_t;

	state_t state;
	state_t state_nxt;
	logic in_word;
	logic [2:0] close_dly;

	// a word is taken only on an enabled valid cycle
	assign in_word = ena && in_valid;

	assign burst_start = in_word && !in_ctrl && (state == CLOSE);
	assign word_acc = burst_start || (in_word && (state == BURST));
	assign burst_close = in_word && in_ctrl && (state == BURST);
	assign result_strobe = close_dly[2];

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (in_word && in_ctrl) state_nxt = CLOSE;
			// closing word opens the next burst as well
			BURST: if (burst_close) state_nxt = CLOSE;
			CLOSE: if (burst_start) state_nxt = BURST;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			state <= IDLE;
			close_dly <= '0;
		end else if (ena) begin
			state <= state_nxt;
			// evolution, two combine stages
			close_dly <= {close_dly[1:0], burst_close};
		end
	end

endmodule

// File: crc24_checker.sv
/*
 * Receive-side CRC24 checker for a stream of 64-bit words.
 * A burst is the data words after a control word plus the next control word.
 * result.valid pulses 4 enabled cycles after the closing word is taken.
 * Everything stalls while ena is low, there is no back-pressure.
 */
`timescale 1ns/1ps

module crc24_checker (
	input  logic                   clk,
	input  logic                   arst,
	input  logic                   ena,
	input  word_pkg::stream_in_t   rx,
	output crc_pkg::burst_result_t result
);

	import crc_pkg::*;

	crc24_t evo;
	logic evo_valid;
	logic burst_start;
	logic word_acc;
	logic burst_close;
	logic result_strobe;
	cover_t covered;
	logic too_long;
	logic word_acc_q;
	cover_t covered_q;
	logic comb_valid;
	crc24_t n1_q;
	crc24_t crc_out;
	crc24_t rx_crc_pipe [3];
	logic [1:0] too_long_pipe;

	crc24_word_evo u_evo (
		.clk(clk), .arst(arst), .ena(ena), .rx(rx),
		.evo(evo), .evo_valid(evo_valid)
	);

	burst_fsm u_fsm (
		.clk(clk), .arst(arst), .ena(ena),
		.in_valid(rx.valid), .in_ctrl(rx.is_ctrl),
		.burst_start(burst_start), .word_acc(word_acc),
		.burst_close(burst_close), .result_strobe(result_strobe)
	);

	burst_counter u_cnt (
		.clk(clk), .arst(arst), .ena(ena),
		.burst_start(burst_start), .word_acc(word_acc),
		.covered(covered), .too_long(too_long)
	);

	// n2 is the rolling CRC itself
	crc24_combine u_comb (
		.clk(clk), .arst(arst), .ena(ena), .valid(comb_valid),
		.covered(covered_q), .evo_dat_0(evo), .evo_dat_n1(n1_q),
		.evo_dat_n2(crc_out), .crc_out(crc_out)
	);

	//////////////////////////////
	// line framing up with the evolution register
	assign comb_valid = word_acc_q && evo_valid;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			word_acc_q <= 1'b0;
			covered_q <= '0;
		end else if (ena) begin
			word_acc_q <= word_acc;
			covered_q <= covered;
		end
	end

	always_ff @(posedge clk) begin
		// contribution of the last burst word
		if (ena && comb_valid) begin
			n1_q <= evo;
		end
		if (ena) begin
			// received field, kept apart from a close that follows soon after
			if (burst_close) begin
				rx_crc_pipe[0] <= rx.word.ctrl.crc;
			end
			rx_crc_pipe[1] <= rx_crc_pipe[0];
			rx_crc_pipe[2] <= rx_crc_pipe[1];
			// counter flag settles one cycle after the close
			too_long_pipe <= {too_long_pipe[0], too_long};
		end
	end

	//////////////////////////////
	// compare and report
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			result <= '0;
		end else if (ena) begin
			result.valid <= result_strobe;
			if (result_strobe) begin
				result.crc <= crc_out;
				result.rx_crc <= rx_crc_pipe[2];
				result.crc_err <= (crc_out != rx_crc_pipe[2]);
				result.too_long <= too_long_pipe[1];
			end
		end
	end

endmodule

// File: tb_crc24_checker.sv
/*
 * Testbench for the CRC24 burst checker.
 * Expected results are queued as each closing word is driven and
 * popped in order as result.valid rises on an enabled cycle.
 * Stops at the first mismatch. Stimulus comes from a fixed-seed LCG.
 */
`timescale 1ns/1ps
`include "crc_macros.svh"

module tb_crc24_checker;

	import word_pkg::*;
	import crc_pkg::*;

	localparam logic [31:0] SEED = 32'hee06715f;
	localparam int RESULT_TIMEOUT = 200;
	localparam int DRAIN_TIMEOUT = 400;

	logic clk;
	logic arst;
	logic ena;
	stream_in_t rx;
	burst_result_t result;

	// data and gap streams kept apart so a burst can be replayed with gaps
	logic [31:0] data_state;
	logic [31:0] gap_state;
	logic [31:0] saved_state;
	burst_result_t exp_q [$];
	bit drained;

	crc24_checker dut (
		.clk(clk),
		.arst(arst),
		.ena(ena),
		.rx(rx),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////
	// random numbers

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] data_rand();
		data_state = lcg(data_state);
		return data_state;
	endfunction

	function automatic logic [31:0] gap_rand();
		gap_state = lcg(gap_state);
		return gap_state;
	endfunction

	//////////////////////////////
	// reference model

	// bit-serial CRC over the burst from an all-ones start and MSB first
	function automatic crc24_t crc24_ref(input logic [`WORD_W-1:0] words [$]);
		crc24_t c;
		logic [`WORD_W-1:0] d;
		logic fb;
		c = '1;
		for (int k = 0; k < words.size(); k++) begin
			d = words[k];
			// CRC field of the control word counts as zero
			if (k == words.size() - 1) begin
				d[`CRC_W-1:0] = '0;
			end
			for (int i = `WORD_W - 1; i >= 0; i--) begin
				fb = c[`CRC_W-1] ^ d[i];
				c = c << 1;
				if (fb) begin
					c = c ^ `CRC_POLY;
				end
			end
		end
		return c;
	endfunction

	//////////////////////////////
	// reporting and compare

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_crc(input crc24_t got, input crc24_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: crc got %h expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flags(input burst_result_t got, input burst_result_t exp);
		if (got.rx_crc !== exp.rx_crc) begin
			$display("** Error at %0t: rx_crc got %h expected %h", $time, got.rx_crc, exp.rx_crc);
			abort_run();
		end
		if (got.crc_err !== exp.crc_err) begin
			$display("** Error at %0t: crc_err got %b expected %b", $time, got.crc_err,
				exp.crc_err);
			abort_run();
		end
		if (got.too_long !== exp.too_long) begin
			$display("** Error at %0t: too_long got %b expected %b", $time, got.too_long,
				exp.too_long);
			abort_run();
		end
	endtask

	// a result counts only if ena was high at the rising edge before this negedge
	initial begin : result_checker
		burst_result_t exp;
		int idle;
		logic ena_prev;
		idle = 0;
		ena_prev = 1'b0;
		forever begin
			@(negedge clk);
			if (result.valid && ena_prev) begin
				if (exp_q.size() == 0) begin
					$display("a result arrived at %0t with no burst outstanding", $time);
					abort_run();
				end else begin
					exp = exp_q.pop_front();
					check_crc(result.crc, exp.crc);
					check_flags(result, exp);
					idle = 0;
				end
			end else if (exp_q.size() != 0) begin
				idle++;
				if (idle > RESULT_TIMEOUT) begin
					$display("timeout, no result arrived within %0d cycles", RESULT_TIMEOUT);
					abort_run();
				end
			end else begin
				idle = 0;
			end
			ena_prev = ena;
		end
	end

	//////////////////////////////
	// stimulus

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		ena = 1'b1;
		rx.valid = 1'b0;
		repeat (n) next_cycle();
	endtask

	// optional gap of ena low or valid low with junk on the bus
	task automatic drive_word(input logic [`WORD_W-1:0] w, input logic ctrl, input bit gaps);
		logic [31:0] r;
		int n;
		n = gaps ? int'(gap_rand() >> 30) : 0;
		repeat (n) begin
			r = gap_rand();
			rx.word.data = {gap_rand(), r};
			rx.is_ctrl = r[0];
			if (r[5]) begin
				ena = 1'b0;
				rx.valid = r[6];
			end else begin
				ena = 1'b1;
				rx.valid = 1'b0;
			end
			next_cycle();
		end
		ena = 1'b1;
		rx.valid = 1'b1;
		rx.word.data = w;
		rx.is_ctrl = ctrl;
		next_cycle();
	endtask

	// n_data data words then the closing control word
	task automatic send_burst(input int n_data, input bit corrupt, input bit gaps);
		logic [`WORD_W-1:0] q [$];
		logic [`WORD_W-1:0] w;
		ctrl_fields_t cw;
		burst_result_t exp;
		for (int i = 0; i < n_data; i++) begin
			w = {data_rand(), data_rand()};
			q.push_back(w);
			drive_word(w, 1'b0, gaps);
		end
		cw.ctrl_type = 8'(data_rand() >> 24);
		cw.rsvd = data_rand();
		cw.crc = '0;
		q.push_back(cw);
		exp.crc = crc24_ref(q);
		exp.rx_crc = exp.crc;
		// single bit flip in the received field
		if (corrupt) begin
			exp.rx_crc = exp.crc ^ (crc24_t'(1) << (data_rand() % `CRC_W));
		end
		exp.crc_err = corrupt;
		exp.too_long = (n_data + 1 > `MAX_BURST_WORDS);
		exp.valid = 1'b1;
		cw.crc = exp.rx_crc;
		exp_q.push_back(exp);
		drive_word(cw, 1'b1, gaps);
	endtask

	task automatic wait_drain(output bit ok);
		int n;
		n = 0;
		ena = 1'b1;
		rx.valid = 1'b0;
		while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
			next_cycle();
			n++;
		end
		// a few quiet cycles to catch stray results
		repeat (10) next_cycle();
		ok = (exp_q.size() == 0);
	endtask

	initial begin
		data_state = SEED;
		gap_state = lcg(SEED);
		arst = 1'b1;
		ena = 1'b0;
		rx = '0;
		repeat (5) @(posedge clk);
		#1;
		arst = 1'b0;

		// data before the first control word gives no result
		for (int i = 0; i < 3; i++) begin
			drive_word({data_rand(), data_rand()}, 1'b0, 1'b0);
		end
		idle_cycles(8);
		drive_word({data_rand(), data_rand()}, 1'b1, 1'b0);

		// shortest bursts with covered 0 and 1
		send_burst(1, 1'b0, 1'b0);
		send_burst(2, 1'b0, 1'b0);

		// back-to-back bursts and then the same bursts again with gaps
		saved_state = data_state;
		for (int b = 0; b < 20; b++) begin
			send_burst(2 + int'((data_rand() >> 16) % 38), 1'b0, 1'b0);
		end
		data_state = saved_state;
		for (int b = 0; b < 20; b++) begin
			send_burst(2 + int'((data_rand() >> 16) % 38), 1'b0, 1'b1);
		end

		// bad received field followed by a clean burst
		send_burst(7, 1'b1, 1'b0);
		send_burst(4, 1'b0, 1'b0);

		// one word over the limit and a normal burst that clears the flag
		send_burst(`MAX_BURST_WORDS, 1'b0, 1'b0);
		send_burst(5, 1'b0, 1'b0);

		wait_drain(drained);
		if (drained) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("timeout, %0d results never arrived", exp_q.size());
			abort_run();
		end
	end

endmodule

// File: sources.f
+incdir+.
word_pkg.sv
crc_pkg.sv
crc24_word_evo.sv
crc24_zero_adv.sv
crc24_combine.sv
burst_counter.sv
burst_fsm.sv
crc24_checker.sv
tb_crc24_checker.sv

// File: Bender.yml
package:
  name: crc24_checker

sources:
  - include_dirs:
      - .
    files:
      - word_pkg.sv
      - crc_pkg.sv
      - crc24_word_evo.sv
      - crc24_zero_adv.sv
      - crc24_combine.sv
      - burst_counter.sv
      - burst_fsm.sv
      - crc24_checker.sv
      - target: test
        files:
          - tb_crc24_checker.sv
